/* source/mips_pkg.sv */
package mips_pkg;

    //////////////////////////////////////////////////////////////////////
    // Instruction word formats.
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    // One 32-bit word, seen either as R-type or as I-type.
    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
    } instr_t;

    //////////////////////////////////////////////////////////////////////
    // Encodings.
    //////////////////////////////////////////////////////////////////////

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    localparam logic [2:0] ALU_ADD = 3'd0;
    localparam logic [2:0] ALU_SUB = 3'd1;
    localparam logic [2:0] ALU_AND = 3'd2;
    localparam logic [2:0] ALU_OR  = 3'd3;
    localparam logic [2:0] ALU_XOR = 3'd4;
    localparam logic [2:0] ALU_SLT = 3'd5;
    localparam logic [2:0] ALU_LUI = 3'd6;

    localparam logic [31:0] RESET_VECTOR = 32'h0000_0004; // First fetch address.
    localparam logic [4:0]  REG_V0       = 5'd2;

    // Control FSM states.
    localparam logic [2:0] ST_FETCH  = 3'd0;
    localparam logic [2:0] ST_DECODE = 3'd1;
    localparam logic [2:0] ST_EXEC   = 3'd2;
    localparam logic [2:0] ST_MEM    = 3'd3;
    localparam logic [2:0] ST_WB     = 3'd4;
    localparam logic [2:0] ST_HALT   = 3'd5;

endpackage

/* source/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic [2:0]  alu_op,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] result
);

    //////////////////////////////////////////////////////////////////////
    // Operation select.
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (alu_op)
            mips_pkg::ALU_ADD: result = a + b;
            mips_pkg::ALU_SUB: result = a - b;
            mips_pkg::ALU_AND: result = a & b;
            mips_pkg::ALU_OR:  result = a | b;
            mips_pkg::ALU_XOR: result = a ^ b;
            mips_pkg::ALU_SLT: begin
                // Signed compare, result is 0 or 1.
                result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            end
            mips_pkg::ALU_LUI: result = {b[15:0], 16'h0000}; // Immediate to upper half.
            default:           result = 32'd0;
        endcase
    end

endmodule

/* source/pc_unit.sv */
`timescale 1ns/1ps

module pc_unit (
    input  logic        clk,
    input  logic        rst,
    input  logic        pc_en,
    input  logic        pc_jump,
    input  logic [31:0] jump_target,
    output logic [31:0] pc
);

    //////////////////////////////////////////////////////////////////////
    // Program counter.
    //////////////////////////////////////////////////////////////////////

    // A jump wins over the sequential increment.
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= mips_pkg::RESET_VECTOR;
        end else if (pc_jump) begin
            pc <= jump_target;
        end else if (pc_en) begin
            pc <= pc + 32'd4; // Next word.
        end
    end

endmodule

/* source/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic        clk,
    input  logic        rst,
    input  logic        reg_write,
    input  logic [4:0]  rs,
    input  logic [4:0]  rt,
    input  logic [4:0]  dest,
    input  logic [31:0] wdata,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    output logic [31:0] register_v0
);

    logic [31:0] regs [0:31];

    //////////////////////////////////////////////////////////////////////
    // Write port.
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (reg_write && (dest != 5'd0)) begin
            regs[dest] <= wdata; // $zero is never written.
        end
    end

    // Combinational read ports.
    assign rs_data = regs[rs];
    assign rt_data = regs[rt];

    assign register_v0 = regs[mips_pkg::REG_V0]; // Result register seen outside.

endmodule

/* source/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode (
    input  logic             clk,
    input  logic             rst,
    input  logic             ir_load,
    input  logic             mdr_load,
    input  logic [31:0]      readdata,
    output mips_pkg::instr_t instr,
    output logic [4:0]       rs,
    output logic [4:0]       rt,
    output logic [4:0]       dest,
    output logic [31:0]      imm_ext,
    output logic [31:0]      mem_data
);

    logic        zero_ext;
    logic [15:0] imm;

    // Instruction register.
    always_ff @(posedge clk) begin
        if (rst) begin
            instr <= '0;
        end else if (ir_load) begin
            instr <= readdata;
        end
    end

    // Memory data register for loads.
    always_ff @(posedge clk) begin
        if (mdr_load) begin
            mem_data <= readdata;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Field extraction.
    //////////////////////////////////////////////////////////////////////

    assign rs  = instr.r_fields.rs;
    assign rt  = instr.i_fields.rt;
    assign imm = instr.i_fields.imm;

    // R-type writes rd, I-type writes rt.
    assign dest = (instr.r_fields.opcode == mips_pkg::OP_RTYPE) ? instr.r_fields.rd
                                                                 : instr.i_fields.rt;

    assign zero_ext = (instr.i_fields.opcode == mips_pkg::OP_ANDI) ||
                      (instr.i_fields.opcode == mips_pkg::OP_ORI);

    assign imm_ext = zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};

endmodule

/* source/cpu_control.sv */
`timescale 1ns/1ps

module cpu_control (
    input  logic             clk,
    input  logic             rst,
    input  logic             waitrequest,
    input  mips_pkg::instr_t instr,
    input  logic [31:0]      rs_data,
    output logic             read,
    output logic             write,
    output logic             active,
    output logic             pc_en,
    output logic             pc_jump,
    output logic             ir_load,
    output logic             mdr_load,
    output logic             reg_write,
    output logic             wb_from_mem,
    output logic             addr_from_alu,
    output logic [2:0]       alu_op,
    output logic             alu_use_imm
);

    logic [2:0] state;
    logic [2:0] state_next;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic       is_jr;
    logic       is_lw;
    logic       is_sw;
    logic       writes_reg;
    logic       bus_done;

    assign opcode   = instr.r_fields.opcode;
    assign funct    = instr.r_fields.funct;
    assign is_jr    = (opcode == mips_pkg::OP_RTYPE) && (funct == mips_pkg::FN_JR);
    assign is_lw    = (opcode == mips_pkg::OP_LW);
    assign is_sw    = (opcode == mips_pkg::OP_SW);
    assign bus_done = (read || write) && !waitrequest; // Avalon transfer accepted.

    //////////////////////////////////////////////////////////////////////
    // Instruction decode to ALU operation and operand source.
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        alu_op      = mips_pkg::ALU_ADD;
        alu_use_imm = 1'b1;
        writes_reg  = 1'b1;
        case (opcode)
            mips_pkg::OP_RTYPE: begin
                alu_use_imm = 1'b0;
                case (funct)
                    mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
                    default:           writes_reg = 1'b0; // JR, unknown funct.
                endcase
            end
            mips_pkg::OP_ADDIU: alu_op = mips_pkg::ALU_ADD;
            mips_pkg::OP_ANDI:  alu_op = mips_pkg::ALU_AND;
            mips_pkg::OP_ORI:   alu_op = mips_pkg::ALU_OR;
            mips_pkg::OP_LUI:   alu_op = mips_pkg::ALU_LUI;
            mips_pkg::OP_LW:    alu_op = mips_pkg::ALU_ADD; // Base plus offset.
            mips_pkg::OP_SW:    writes_reg = 1'b0;
            default:            writes_reg = 1'b0; // Unknown opcodes act as no-ops.
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // State sequencing.
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            mips_pkg::ST_FETCH: begin
                if (bus_done) begin
                    state_next = mips_pkg::ST_DECODE;
                end
            end
            mips_pkg::ST_DECODE: state_next = mips_pkg::ST_EXEC;
            mips_pkg::ST_EXEC: begin
                if (is_jr && (rs_data == 32'd0)) begin
                    state_next = mips_pkg::ST_HALT; // JR to zero stops the CPU.
                end else if (is_lw || is_sw) begin
                    state_next = mips_pkg::ST_MEM;
                end else begin
                    state_next = mips_pkg::ST_WB;
                end
            end
            mips_pkg::ST_MEM: begin
                if (bus_done) begin
                    state_next = mips_pkg::ST_WB;
                end
            end
            mips_pkg::ST_WB: state_next = mips_pkg::ST_FETCH;
            default:         state_next = mips_pkg::ST_HALT;
        endcase
    end

    // Strobes are registered and follow the state being entered.
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mips_pkg::ST_FETCH;
            read  <= 1'b0;
            write <= 1'b0;
        end else begin
            state <= state_next;
            read  <= (state_next == mips_pkg::ST_FETCH) ||
                     ((state_next == mips_pkg::ST_MEM) && is_lw);
            write <= (state_next == mips_pkg::ST_MEM) && is_sw;
        end
    end

    assign active        = (state != mips_pkg::ST_HALT);
    assign ir_load       = (state == mips_pkg::ST_FETCH) && bus_done;
    assign mdr_load      = (state == mips_pkg::ST_MEM) && read && !waitrequest;
    assign addr_from_alu = (state == mips_pkg::ST_MEM);
    assign pc_jump       = (state == mips_pkg::ST_EXEC) && is_jr && (rs_data != 32'd0);
    assign pc_en         = (state == mips_pkg::ST_WB) && !is_jr; // JR already moved the PC.
    assign reg_write     = (state == mips_pkg::ST_WB) && writes_reg;
    assign wb_from_mem   = is_lw;

endmodule

/* source/mips_cpu.sv */
`timescale 1ns/1ps

module mips_cpu (
    input  logic        clk,
    input  logic        rst,
    input  logic        waitrequest,
    input  logic [31:0] readdata,
    output logic        active,
    output logic [31:0] register_v0,
    output logic [31:0] address,
    output logic        read,
    output logic        write,
    output logic [31:0] writedata
);

    logic             pc_en;
    logic             pc_jump;
    logic             ir_load;
    logic             mdr_load;
    logic             reg_write;
    logic             wb_from_mem;
    logic             addr_from_alu;
    logic [2:0]       alu_op;
    logic             alu_use_imm;
    logic [31:0]      pc;
    mips_pkg::instr_t instr;
    logic [4:0]       rs;
    logic [4:0]       rt;
    logic [4:0]       dest;
    logic [31:0]      imm_ext;
    logic [31:0]      mem_data;
    logic [31:0]      rs_data;
    logic [31:0]      rt_data;
    logic [31:0]      alu_b;
    logic [31:0]      result;
    logic [31:0]      wdata;

    //////////////////////////////////////////////////////////////////////
    // Datapath selection.
    //////////////////////////////////////////////////////////////////////

    assign alu_b     = alu_use_imm ? imm_ext : rt_data;
    assign address   = addr_from_alu ? result : pc;   // Data access or fetch.
    assign wdata     = wb_from_mem ? mem_data : result;
    assign writedata = rt_data;                       // Store source.

    cpu_control u_control (
        .clk           (clk),
        .rst           (rst),
        .waitrequest   (waitrequest),
        .instr         (instr),
        .rs_data       (rs_data),
        .read          (read),
        .write         (write),
        .active        (active),
        .pc_en         (pc_en),
        .pc_jump       (pc_jump),
        .ir_load       (ir_load),
        .mdr_load      (mdr_load),
        .reg_write     (reg_write),
        .wb_from_mem   (wb_from_mem),
        .addr_from_alu (addr_from_alu),
        .alu_op        (alu_op),
        .alu_use_imm   (alu_use_imm)
    );

    pc_unit u_pc (
        .clk         (clk),
        .rst         (rst),
        .pc_en       (pc_en),
        .pc_jump     (pc_jump),
        .jump_target (rs_data),
        .pc          (pc)
    );

    instr_decode u_decode (
        .clk      (clk),
        .rst      (rst),
        .ir_load  (ir_load),
        .mdr_load (mdr_load),
        .readdata (readdata),
        .instr    (instr),
        .rs       (rs),
        .rt       (rt),
        .dest     (dest),
        .imm_ext  (imm_ext),
        .mem_data (mem_data)
    );

    register_file u_regs (
        .clk         (clk),
        .rst         (rst),
        .reg_write   (reg_write),
        .rs          (rs),
        .rt          (rt),
        .dest        (dest),
        .wdata       (wdata),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .register_v0 (register_v0)
    );

    alu u_alu (
        .alu_op (alu_op),
        .a      (rs_data),
        .b      (alu_b),
        .result (result)
    );

endmodule

/* testbench/avalon_ram_model.sv */
`timescale 1ns/1ps

module avalon_ram_model (
    input  logic        clk,
    input  logic        stall_mode,
    input  logic        preload_en,
    input  logic [7:0]  preload_addr,
    input  logic [31:0] preload_data,
    input  logic [31:0] address,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] writedata,
    output logic        waitrequest,
    output logic [31:0] readdata
);

    logic [31:0] mem [0:63];        // 256 bytes, word index from address bits 7:2.
    logic        stall_q = 1'b0;
    logic        stall_bit = 1'b0;
    integer      seed = 32'h7089_ae39;
    logic [31:0] rnd;

    // Preload has priority over a CPU write.
    always @(posedge clk) begin
        stall_q <= stall_mode;
        if (preload_en) begin
            mem[preload_addr[7:2]] <= preload_data;
        end else if (write && !waitrequest) begin
            mem[address[7:2]] <= writedata; // Store accepted.
        end
    end

    // New stall value each falling edge.
    always @(negedge clk) begin
        if (stall_q) begin
            rnd = $random(seed);
            stall_bit <= rnd[0];
        end else begin
            stall_bit <= 1'b0;
        end
    end

    assign waitrequest = stall_bit;
    assign readdata    = read ? mem[address[7:2]] : 32'h0; // Valid with the accepted read.

endmodule

/* testbench/mips_cpu_tb.sv */
`timescale 1ns/1ps

module mips_cpu_tb;

    localparam int         RESET_CYCLES    = 10;
    localparam int         QUIET_CYCLES    = 4;  // Bus watched this long after a halt.
    localparam int         STALL_ALLOWANCE = 8;
    localparam logic [7:0] PROG_BASE       = 8'h04;

    typedef logic [8*24-1:0] name_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        stall_mode;
    logic        preload_en;
    logic [7:0]  preload_addr;
    logic [31:0] preload_data;
    logic        waitrequest;
    logic [31:0] readdata;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic        read;
    logic        write;
    logic [31:0] writedata;

    name_t       test_names [$];
    int          test_stalls [$];
    logic [31:0] test_expect [$];
    int          test_first [$];
    int          test_len [$];
    logic [31:0] prog_words [$];
    name_t       current_name;
    logic        file_ok;
    int          watchdog_cycles = 0;
    int          pass_count = 0;
    int          fail_count = 0;

    always #10 clk = ~clk;

    mips_cpu u_dut (
        .clk         (clk),
        .rst         (rst),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata)
    );

    avalon_ram_model u_ram (
        .clk          (clk),
        .stall_mode   (stall_mode),
        .preload_en   (preload_en),
        .preload_addr (preload_addr),
        .preload_data (preload_data),
        .address      (address),
        .read         (read),
        .write        (write),
        .writedata    (writedata),
        .waitrequest  (waitrequest),
        .readdata     (readdata)
    );

    ///////////////////////////////////////////////////////////////////////
    // Test file reader.
    ///////////////////////////////////////////////////////////////////////

    task automatic read_test_file();
        int               fd;
        int               n;
        int               i;
        int               count;
        int               stall_in;
        name_t            tok;
        name_t            name_in;
        logic [31:0]      value;
        logic [8*100-1:0] rest;
        file_ok = 1'b1;
        fd = $fopen("testbench/cpu_tests.txt", "r");
        if (fd == 0) begin
            file_ok = 1'b0;
        end else begin
            while (file_ok && ($fscanf(fd, "%s", tok) == 1)) begin
                if (tok == name_t'("#")) begin
                    n = $fgets(rest, fd);                 // Comment line.
                end else if (tok == name_t'("test")) begin
                    n = $fscanf(fd, "%s %d %h %d", name_in, stall_in, value, count);
                    if (n != 4) begin
                        file_ok = 1'b0;
                    end
                    test_names.push_back(name_in);
                    test_stalls.push_back(stall_in);
                    test_expect.push_back(value);
                    test_first.push_back(prog_words.size());
                    test_len.push_back(count);
                    for (i = 0; i < count; i++) begin
                        n = $fscanf(fd, "%h", value);
                        prog_words.push_back(value);
                    end
                end else begin
                    file_ok = 1'b0;
                end
            end
            $fclose(fd);
        end
    endtask

    ///////////////////////////////////////////////////////////////////////
    // One test: reset and preload, run to the halt, then check.
    ///////////////////////////////////////////////////////////////////////

    task automatic run_test(input int idx);
        int   c;
        int   cycles;
        logic ok;
        ok           = 1'b1;
        current_name = test_names[idx];
        rst          = 1'b1;
        stall_mode   = (test_stalls[idx] != 0);
        // Program goes in while the CPU is held in reset.
        for (c = 0; (c < RESET_CYCLES) || (c < test_len[idx]); c++) begin
            if (c < test_len[idx]) begin
                preload_en   = 1'b1;
                preload_addr = PROG_BASE + 8'(4 * c);
                preload_data = prog_words[test_first[idx] + c];
            end else begin
                preload_en = 1'b0;
            end
            @(negedge clk);
        end
        preload_en = 1'b0;
        rst        = 1'b0;
        cycles     = 0;
        while (active) begin
            @(negedge clk);
            cycles++;
        end
        assert (register_v0 == test_expect[idx]) else begin
            $display("FAIL %0s: expected v0 %08h, actual %08h",
                     current_name, test_expect[idx], register_v0);
            ok = 1'b0;
        end
        for (c = 0; c < QUIET_CYCLES; c++) begin
            assert (!read && !write && !active) else begin
                $display("ERROR %0s: bus strobe or active seen after the halt", current_name);
                ok = 1'b0;
            end
            @(negedge clk);
        end
        if (ok) begin
            pass_count++;
            $display("%0s: ok, v0 %08h after %0d cycles", current_name, register_v0, cycles);
        end else begin
            fail_count++;
            $display("%0s: wrong, v0 %08h after %0d cycles", current_name, register_v0, cycles);
        end
    endtask

    initial begin
        int i;
        rst          = 1'b1;
        stall_mode   = 1'b0;
        preload_en   = 1'b0;
        preload_addr = 8'h00;
        preload_data = 32'h0;
        read_test_file();
        if (!file_ok || (test_names.size() == 0)) begin
            $display("ERROR: test file testbench/cpu_tests.txt is missing or malformed");
            fail_count++;
        end else begin
            // Every word may cost a memory instruction with stalls, plus reset and idle time.
            watchdog_cycles = prog_words.size() * 5 * STALL_ALLOWANCE
                            + test_names.size() * (RESET_CYCLES + QUIET_CYCLES);
            @(negedge clk);
            for (i = 0; i < test_names.size(); i++) begin
                run_test(i);
            end
        end
        $display("Tests run %0d, passed %0d, failed %0d",
                 test_names.size(), pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Watchdog.
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("ERROR: test %0s never halted within %0d cycles", current_name, watchdog_cycles);
        $display("Testbench failed");
        $finish;
    end

endmodule

/* testbench/cpu_tests.txt */
# test <name> <stall: 0 none, 1 random> <expected v0 hex> <word count>
# then the program words in hex, loaded from byte address 0x04 upward
test ori_of_addiu 0 fffff0ff 4
2408f0f0 240900ff 01091025 00000008
# LUI and ORI build a constant, ANDI masks with a zero-extended immediate
test lui_ori_andi 0 1234200d 5
3c081234 3508abcd 31098ff0 01091026 00000008
# ADDU, SUBU, signed SLT and XOR on negative operands
test alu_signed 0 fffffffa 7
2408fffb 24090003 01095021 01495023 0149582a 014b1026 00000008
# Store to 0x84 and load back
test sw_lw 0 cafef00d 6
24080080 3c09cafe 3529f00d ad090004 8d020004 00000008
# Register zero ignores a write
test zero_reg 0 00000000 4
24000055 24020007 00001021 00000008
# JR to 0x18 skips three words
test jr_skip 0 00000123 7
24080018 01000008 24020bad 2402dead 2442ffff 24420123 00000008
# First test again with random waitrequest
test ori_stalls 1 fffff0ff 4
2408f0f0 240900ff 01091025 00000008

/* flist.f */
source/mips_pkg.sv
source/alu.sv
source/pc_unit.sv
source/register_file.sv
source/instr_decode.sv
source/cpu_control.sv
source/mips_cpu.sv
testbench/avalon_ram_model.sv
testbench/mips_cpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the CPU testbench with Verilator from the project root.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module mips_cpu_tb -f flist.f -Mdir obj_dir
out=$(./obj_dir/Vmips_cpu_tb)
echo "$out"
if echo "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
